/* iigs_disk_ctrl.f */
common/iigs_blk_pkg.sv
common/blk_req_if.sv
hdd/hdd_request.sv
floppy/floppy_track_loader.sv
design/blk_arbiter.sv
design/iigs_disk_ctrl.sv
test/tb_iigs_disk_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, exit status is the verdict
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_iigs_disk_ctrl \
	-f iigs_disk_ctrl.f \
	-o tb_iigs_disk_ctrl
./obj_dir/tb_iigs_disk_ctrl

/* test/tb_iigs_disk_ctrl.sv */
`timescale 1ns/10ps

module tb_iigs_disk_ctrl;
	import iigs_blk_pkg::*;

	localparam int TRACK_BLOCKS = 13;
	localparam int NUM_ROWS = 9;
	localparam int IMG_BYTES = 33554432;

	typedef enum logic [2:0] {
		OP_HDD_MOUNT,
		OP_HDD_READ,
		OP_HDD_WRITE,
		OP_FD_MOUNT,
		OP_FD_TRACK,
		OP_ALL
	} op_t;

	// One table row
	// unit is the HDD unit or floppy drive
	// arg is image size, sector or track depending on op
	typedef struct packed {
		op_t      op;
		int       unit;
		int       arg;
		int       t1;
		int       t2;
		bit       ro;
		blk_dev_t exp_dev;
		int       exp_cnt;
		blk_lba_t exp_base;
	} row_t;

	typedef struct packed {
		blk_dev_t dev;
		blk_lba_t lba;
	} xfer_t;

	logic          clk_sys, reset, hdd_read, hdd_write, img_readonly, sd_ack;
	hdd_unit_t     hdd_unit;
	hdd_sector_t   hdd_sector;
	floppy_track_t fd1_track, fd2_track;
	logic [3:0]    img_mounted;
	img_size_t     img_size;
	logic          hdd_busy, sd_rd, sd_wr;
	logic [1:0]    hdd_mounted, hdd_protect, fd_busy, fd_ready;
	blk_lba_t      sd_lba;
	blk_dev_t      sd_dev;

	row_t  rows [NUM_ROWS];
	// Host transfers seen since the last row check
	xfer_t got_q [$];
	bit    got_wr [$];

	iigs_disk_ctrl #(.TRACK_BLOCKS(TRACK_BLOCKS)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (NUM_ROWS * TRACK_BLOCKS * 20) @(posedge clk_sys);
		$display("Timeout, the test table did not finish in time");
		$display("Simulation FAILED");
		$fatal(1);
	end

	task automatic fail_now(input string msg);
		$display("FAILED at %0t: %s", $time, msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic check_lba(input blk_lba_t got, input blk_lba_t exp, input string what);
		if (got !== exp)
			fail_now($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_dev(input blk_dev_t got, input blk_dev_t exp, input string what);
		if (got !== exp)
			fail_now($sformatf("%s is %0d, expected %0d", what, got, exp));
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		if (got !== exp)
			fail_now($sformatf("%s is %0b, expected %0b", what, got, exp));
	endtask

	task automatic set_track(input int drive, input int trk);
		if (drive == 0)
			fd1_track <= floppy_track_t'(trk);
		else
			fd2_track <= floppy_track_t'(trk);
	endtask

	// Called on a rising edge
	// busy must rise on the second edge after the pulse
	task automatic start_hdd(input bit wr, input int unit, input int sector);
		hdd_unit   <= hdd_unit_t'(unit);
		hdd_sector <= hdd_sector_t'(sector);
		hdd_read   <= ~wr;
		hdd_write  <= wr;
		@(posedge clk_sys);
		hdd_read  <= 1'b0;
		hdd_write <= 1'b0;
		@(posedge clk_sys);
		check_flag(hdd_busy, 1'b0, "hdd_busy one edge after pulse");
		@(posedge clk_sys);
		check_flag(hdd_busy, 1'b1, "hdd_busy two edges after pulse");
	endtask

	task automatic compare_row(input row_t r);
		xfer_t exp_q [$];
		int    idx;
		bit    exp_wr;
		exp_wr = (r.op == OP_HDD_WRITE);
		if (r.op == OP_HDD_READ || r.op == OP_HDD_WRITE || r.op == OP_ALL)
			exp_q.push_back({r.exp_dev, r.exp_base});
		if (r.op == OP_FD_MOUNT || r.op == OP_FD_TRACK) begin
			for (int i = 0; i < r.exp_cnt; i++)
				exp_q.push_back({r.exp_dev, blk_lba_t'(r.exp_base + i)});
		end
		// Both drives reload their new tracks alongside the HDD read
		if (r.op == OP_ALL) begin
			for (int i = 0; i < r.exp_cnt; i++) begin
				exp_q.push_back({2'd2, blk_lba_t'(r.t1 * TRACK_BLOCKS + i)});
				exp_q.push_back({2'd3, blk_lba_t'(r.t2 * TRACK_BLOCKS + i)});
			end
		end
		if (got_q.size() != exp_q.size())
			fail_now($sformatf("%0d host transfers, expected %0d", got_q.size(), exp_q.size()));
		foreach (got_q[k]) begin
			if (r.op != OP_ALL)
				check_dev(got_q[k].dev, r.exp_dev, "sd_dev");
			// Oldest outstanding block of that device keeps per-drive order
			idx = -1;
			for (int j = exp_q.size() - 1; j >= 0; j--) begin
				if (exp_q[j].dev == got_q[k].dev)
					idx = j;
			end
			if (idx < 0)
				fail_now("host transfer on a device with no block outstanding");
			check_lba(got_q[k].lba, exp_q[idx].lba, "sd_lba");
			check_flag(got_wr[k], exp_wr, "sd_wr direction");
			exp_q.delete(idx);
		end
		got_q.delete();
		got_wr.delete();
	endtask

	// Host side answers one request at a time with random delays
	initial begin : host_responder
		int unsigned hold;
		sd_ack = 1'b0;
		void'($urandom(32'h3345));
		forever begin
			@(posedge clk_sys);
			check_flag(sd_rd & sd_wr, 1'b0, "sd_rd and sd_wr together");
			if (sd_rd | sd_wr) begin
				got_q.push_back({sd_dev, sd_lba});
				got_wr.push_back(sd_wr);
				hold = 1 + ($urandom % 8);
				repeat (hold) @(posedge clk_sys);
				sd_ack <= 1'b1;
				hold = 1 + ($urandom % 4);
				repeat (hold) @(posedge clk_sys);
				sd_ack <= 1'b0;
				@(posedge clk_sys);
				check_flag(sd_rd | sd_wr, 1'b0, "host request overlapping transfer");
			end
		end
	end

	initial begin
		row_t r;
		rows[0] = '{OP_HDD_MOUNT, 1, IMG_BYTES, 0, 0, 1'b1, 2'd0, 0, 0};
		rows[1] = '{OP_HDD_READ, 1, 291, 0, 0, 1'b0, 2'd1, 1, 291};
		rows[2] = '{OP_HDD_MOUNT, 0, IMG_BYTES, 0, 0, 1'b0, 2'd0, 0, 0};
		rows[3] = '{OP_HDD_WRITE, 0, 1110, 0, 0, 1'b0, 2'd0, 1, 1110};
		// Zero size ejects unit 0
		rows[4] = '{OP_HDD_MOUNT, 0, 0, 0, 0, 1'b0, 2'd0, 0, 0};
		rows[5] = '{OP_FD_MOUNT, 0, 5, 0, 0, 1'b0, 2'd2, TRACK_BLOCKS, 5 * TRACK_BLOCKS};
		rows[6] = '{OP_FD_TRACK, 0, 7, 0, 0, 1'b0, 2'd2, TRACK_BLOCKS, 7 * TRACK_BLOCKS};
		rows[7] = '{OP_FD_MOUNT, 1, 3, 0, 0, 1'b0, 2'd3, TRACK_BLOCKS, 3 * TRACK_BLOCKS};
		rows[8] = '{OP_ALL, 1, 1911, 9, 4, 1'b0, 2'd1, TRACK_BLOCKS, 1911};
		reset = 1'b1;
		hdd_read = 1'b0;
		hdd_write = 1'b0;
		hdd_unit = '0;
		hdd_sector = '0;
		fd1_track = '0;
		fd2_track = '0;
		img_mounted = '0;
		img_size = '0;
		img_readonly = 1'b0;
		repeat (2) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);
		check_flag(sd_rd | sd_wr, 1'b0, "host request after reset");
		check_flag(hdd_busy, 1'b0, "hdd_busy after reset");
		check_flag(|fd_busy, 1'b0, "fd_busy after reset");
		check_flag(|fd_ready, 1'b0, "fd_ready after reset");
		check_flag(|hdd_mounted, 1'b0, "hdd_mounted after reset");
		check_flag(|hdd_protect, 1'b0, "hdd_protect after reset");
		foreach (rows[n]) begin
			r = rows[n];
			@(posedge clk_sys);
			case (r.op)
				OP_HDD_MOUNT: begin
					img_size     <= img_size_t'(r.arg);
					img_readonly <= r.ro;
					img_mounted  <= 4'(1 << r.unit);
					@(posedge clk_sys);
					img_mounted <= '0;
					@(posedge clk_sys);
					check_flag(hdd_mounted[r.unit], r.arg != 0, "hdd_mounted");
					check_flag(hdd_protect[r.unit], r.ro, "hdd_protect");
				end
				OP_HDD_READ, OP_HDD_WRITE: begin
					start_hdd(r.op == OP_HDD_WRITE, r.unit, r.arg);
					while (hdd_busy) @(posedge clk_sys);
				end
				OP_FD_MOUNT: begin
					set_track(r.unit, r.arg);
					img_size    <= img_size_t'(143360);
					img_mounted <= 4'(1 << (FLOPPY_DEV_BASE + r.unit));
					@(posedge clk_sys);
					img_mounted <= '0;
					@(posedge clk_sys);
					check_flag(fd_busy[r.unit], 1'b1, "fd_busy one cycle after mount");
					while (!fd_ready[r.unit]) @(posedge clk_sys);
				end
				OP_FD_TRACK: begin
					set_track(r.unit, r.arg);
					@(posedge clk_sys);
					check_flag(fd_ready[r.unit], 1'b0, "fd_ready after track change");
					@(posedge clk_sys);
					check_flag(fd_busy[r.unit], 1'b1, "fd_busy one cycle after track change");
					while (!fd_ready[r.unit]) @(posedge clk_sys);
				end
				default: begin
					set_track(0, r.t1);
					set_track(1, r.t2);
					start_hdd(1'b0, r.unit, r.arg);
					while (hdd_busy || fd_ready != 2'b11) @(posedge clk_sys);
				end
			endcase
			// Quiet time so any stray transfer shows up in this row
			repeat (20) @(posedge clk_sys);
			compare_row(r);
		end
		$display("Simulation PASSED");
		$finish;
	end

endmodule

/* design/iigs_disk_ctrl.sv */
`timescale 1ns/10ps

module iigs_disk_ctrl #(
	parameter int TRACK_BLOCKS = 13
) (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic                             hdd_read,
	input  logic                             hdd_write,
	input  iigs_blk_pkg::hdd_unit_t          hdd_unit,
	input  iigs_blk_pkg::hdd_sector_t        hdd_sector,
	input  iigs_blk_pkg::floppy_track_t      fd1_track,
	input  iigs_blk_pkg::floppy_track_t      fd2_track,
	input  logic [3:0]                       img_mounted,
	input  iigs_blk_pkg::img_size_t          img_size,
	input  logic                             img_readonly,
	input  logic                             sd_ack,
	output logic                             hdd_busy,
	output logic [iigs_blk_pkg::NUM_HDD-1:0] hdd_mounted,
	output logic [iigs_blk_pkg::NUM_HDD-1:0] hdd_protect,
	output logic [1:0]                       fd_busy,
	output logic [1:0]                       fd_ready,
	output iigs_blk_pkg::blk_lba_t           sd_lba,
	output logic                             sd_rd,
	output logic                             sd_wr,
	output iigs_blk_pkg::blk_dev_t           sd_dev
);
	import iigs_blk_pkg::*;

	// Unit of the HDD request in flight, tagged onto sd_dev
	hdd_unit_t hdd_active_unit;

	// One request channel per peer
	blk_req_if hdd_bus ();
	blk_req_if fd1_bus ();
	blk_req_if fd2_bus ();

	hdd_request hdd_seq (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.hdd_read     (hdd_read),
		.hdd_write    (hdd_write),
		.hdd_unit     (hdd_unit),
		.hdd_sector   (hdd_sector),
		.img_mounted  (img_mounted[NUM_HDD-1:0]),
		.img_size     (img_size),
		.img_readonly (img_readonly),
		.hdd_busy     (hdd_busy),
		.hdd_mounted  (hdd_mounted),
		.hdd_protect  (hdd_protect),
		.active_unit  (hdd_active_unit),
		.bus          (hdd_bus.client)
	);

	floppy_track_loader #(.TRACK_BLOCKS(TRACK_BLOCKS)) fd1_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.track        (fd1_track),
		.mount_strobe (img_mounted[FLOPPY_DEV_BASE]),
		.img_size     (img_size),
		.busy         (fd_busy[0]),
		.ready        (fd_ready[0]),
		.bus          (fd1_bus.client)
	);

	floppy_track_loader #(.TRACK_BLOCKS(TRACK_BLOCKS)) fd2_loader (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.track        (fd2_track),
		.mount_strobe (img_mounted[FLOPPY_DEV_BASE+1]),
		.img_size     (img_size),
		.busy         (fd_busy[1]),
		.ready        (fd_ready[1]),
		.bus          (fd2_bus.client)
	);

	blk_arbiter arb0 (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.hdd_unit (hdd_active_unit),
		.sd_ack   (sd_ack),
		.hdd_bus  (hdd_bus.arbiter),
		.fd1_bus  (fd1_bus.arbiter),
		.fd2_bus  (fd2_bus.arbiter),
		.sd_lba   (sd_lba),
		.sd_rd    (sd_rd),
		.sd_wr    (sd_wr),
		.sd_dev   (sd_dev)
	);

endmodule

/* design/blk_arbiter.sv */
`timescale 1ns/10ps

module blk_arbiter (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  iigs_blk_pkg::hdd_unit_t hdd_unit,
	input  logic                    sd_ack,
	blk_req_if.arbiter              hdd_bus,
	blk_req_if.arbiter              fd1_bus,
	blk_req_if.arbiter              fd2_bus,
	output iigs_blk_pkg::blk_lba_t  sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output iigs_blk_pkg::blk_dev_t  sd_dev
);
	import iigs_blk_pkg::*;

	// Client index, 0 is the HDD sequencer
	typedef logic [1:0] client_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_OWNED
	} arb_state_t;

	arb_state_t             state;
	client_t                grant;
	client_t                last_grant;
	client_t                pick;
	blk_dev_t               pick_dev;
	blk_lba_t               lba_in [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0] rd_in;
	logic [NUM_CLIENTS-1:0] wr_in;
	logic [NUM_CLIENTS-1:0] req;
	logic                   old_ack;

	// Next requester after the last owner, wrapping around
	function automatic client_t next_client(input logic [NUM_CLIENTS-1:0] r,
		input client_t last);
		client_t sel;
		int      idx;
		sel = last;
		// Walk from farthest to nearest so the nearest requester wins
		for (int i = NUM_CLIENTS; i >= 1; i--) begin
			idx = (int'(last) + i) % NUM_CLIENTS;
			if (r[idx])
				sel = client_t'(idx);
		end
		return sel;
	endfunction

	assign rd_in     = {fd2_bus.rd, fd1_bus.rd, hdd_bus.rd};
	assign wr_in     = {fd2_bus.wr, fd1_bus.wr, hdd_bus.wr};
	assign req       = rd_in | wr_in;
	assign lba_in[0] = hdd_bus.lba;
	assign lba_in[1] = fd1_bus.lba;
	assign lba_in[2] = fd2_bus.lba;

	assign pick = next_client(req, last_grant);

	// HDD carries its own unit, floppies map onto images 2 and 3
	assign pick_dev = (pick == 2'd0) ? blk_dev_t'(hdd_unit) :
		blk_dev_t'(FLOPPY_DEV_BASE + int'(pick) - 1);

	// Ack only reaches the owner
	assign hdd_bus.ack = sd_ack & (state == ARB_OWNED) & (grant == 2'd0);
	assign fd1_bus.ack = sd_ack & (state == ARB_OWNED) & (grant == 2'd1);
	assign fd2_bus.ack = sd_ack & (state == ARB_OWNED) & (grant == 2'd2);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= ARB_IDLE;
			grant      <= '0;
			last_grant <= client_t'(NUM_CLIENTS - 1);
			old_ack    <= 1'b0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			sd_dev     <= '0;
		end else begin
			old_ack <= sd_ack;
			case (state)
				ARB_IDLE: begin
					if (|req) begin
						state  <= ARB_OWNED;
						grant  <= pick;
						sd_rd  <= rd_in[pick];
						sd_wr  <= wr_in[pick];
						sd_lba <= lba_in[pick];
						sd_dev <= pick_dev;
					end
				end
				ARB_OWNED: begin
					// Host took the request
					if (sd_ack & ~old_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
					end else if (~sd_ack & old_ack) begin
						state      <= ARB_IDLE;
						last_grant <= grant;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Owner cannot change under a running transfer
	a_grant_hold: assert property (@(posedge clk_sys) disable iff (reset)
		sd_ack |=> $stable(grant));

	a_one_dir: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

endmodule

/* floppy/floppy_track_loader.sv */
`timescale 1ns/10ps

module floppy_track_loader #(
	parameter int TRACK_BLOCKS = 13
) (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  iigs_blk_pkg::floppy_track_t track,
	input  logic                        mount_strobe,
	input  iigs_blk_pkg::img_size_t     img_size,
	output logic                        busy,
	output logic                        ready,
	blk_req_if.client                   bus
);
	import iigs_blk_pkg::*;

	localparam int CNT_W = (TRACK_BLOCKS > 1) ? $clog2(TRACK_BLOCKS) : 1;

	typedef enum logic [1:0] {
		FD_IDLE,
		FD_REQUEST,
		FD_WAIT_DONE
	} fd_state_t;

	fd_state_t      state;
	floppy_track_t  cur_track;
	logic [CNT_W-1:0] blk_cnt;
	logic           mounted;
	logic           track_valid;
	logic           need_load;
	logic           old_ack;
	logic           rd_q;
	logic           mount_go;
	logic           reload;
	logic           start;
	logic           ack_rise;
	logic           ack_fall;
	logic           last_blk;

	assign ack_rise = bus.ack & ~old_ack;
	assign ack_fall = ~bus.ack & old_ack;
	assign mount_go = mount_strobe & (img_size != '0);
	assign last_blk = (blk_cnt == CNT_W'(TRACK_BLOCKS - 1));

	// New image, a remount held over from a load, or the head moved
	assign reload = mount_go | need_load | (mounted & (track != cur_track));

	// Loads launch from idle or right after a block completes
	assign start = reload & ((state == FD_IDLE) | ((state == FD_WAIT_DONE) & ack_fall));

	// First block of the track is track * TRACK_BLOCKS
	assign bus.lba = blk_lba_t'(cur_track) * blk_lba_t'(TRACK_BLOCKS) + blk_lba_t'(blk_cnt);
	assign bus.rd  = rd_q;
	assign bus.wr  = 1'b0;

	assign busy  = (state != FD_IDLE);
	assign ready = mounted & track_valid & (cur_track == track) & (state == FD_IDLE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state       <= FD_IDLE;
			cur_track   <= '0;
			blk_cnt     <= '0;
			mounted     <= 1'b0;
			track_valid <= 1'b0;
			need_load   <= 1'b0;
			old_ack     <= 1'b0;
			rd_q        <= 1'b0;
		end else begin
			old_ack   <= bus.ack;
			need_load <= (need_load | mount_go) & ~start;
			if (mount_strobe) begin
				mounted     <= (img_size != '0);
				track_valid <= 1'b0;
			end
			if (start) begin
				cur_track   <= track;
				blk_cnt     <= '0;
				rd_q        <= 1'b1;
				track_valid <= 1'b0;
				state       <= FD_REQUEST;
			end else begin
				case (state)
					FD_REQUEST: begin
						if (ack_rise) begin
							rd_q  <= 1'b0;
							state <= FD_WAIT_DONE;
						end
					end
					FD_WAIT_DONE: begin
						if (ack_fall) begin
							// Ejected mid-track, abandon the rest
							if (!mounted) begin
								state <= FD_IDLE;
							end else if (last_blk) begin
								state       <= FD_IDLE;
								track_valid <= 1'b1;
							end else begin
								blk_cnt <= blk_cnt + 1'b1;
								rd_q    <= 1'b1;
								state   <= FD_REQUEST;
							end
						end
					end
					default: state <= FD_IDLE;
				endcase
			end
		end
	end

endmodule

/* hdd/hdd_request.sv */
`timescale 1ns/10ps

module hdd_request (
	input  logic                              clk_sys,
	input  logic                              reset,
	input  logic                              hdd_read,
	input  logic                              hdd_write,
	input  iigs_blk_pkg::hdd_unit_t           hdd_unit,
	input  iigs_blk_pkg::hdd_sector_t         hdd_sector,
	input  logic [iigs_blk_pkg::NUM_HDD-1:0]  img_mounted,
	input  iigs_blk_pkg::img_size_t           img_size,
	input  logic                              img_readonly,
	output logic                              hdd_busy,
	output logic [iigs_blk_pkg::NUM_HDD-1:0]  hdd_mounted,
	output logic [iigs_blk_pkg::NUM_HDD-1:0]  hdd_protect,
	output iigs_blk_pkg::hdd_unit_t           active_unit,
	blk_req_if.client                         bus
);
	import iigs_blk_pkg::*;

	typedef enum logic {
		HDD_IDLE,
		HDD_ACTIVE
	} hdd_state_t;

	hdd_state_t  state;
	hdd_sector_t sector_q;
	logic        read_pending;
	logic        write_pending;
	logic        serving_write;
	logic        old_ack;
	logic        rd_q;
	logic        wr_q;
	logic        ack_rise;
	logic        ack_fall;
	logic        new_req;

	assign ack_rise = bus.ack & ~old_ack;
	assign ack_fall = ~bus.ack & old_ack;

	// Fresh request from the CPU side with nothing queued yet
	assign new_req = (hdd_read | hdd_write) & (state == HDD_IDLE) &
		~(read_pending | write_pending);

	assign bus.lba = blk_lba_t'(sector_q);
	assign bus.rd  = rd_q;
	assign bus.wr  = wr_q;

	// Unit and sector captured with the first pulse
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			active_unit <= hdd_unit;
			sector_q    <= hdd_sector;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state         <= HDD_IDLE;
			hdd_busy      <= 1'b0;
			read_pending  <= 1'b0;
			write_pending <= 1'b0;
			serving_write <= 1'b0;
			old_ack       <= 1'b0;
			rd_q          <= 1'b0;
			wr_q          <= 1'b0;
		end else begin
			old_ack <= bus.ack;
			// Pulses seen while busy fold into the queued flags
			read_pending  <= read_pending | hdd_read;
			write_pending <= write_pending | hdd_write;
			case (state)
				HDD_IDLE: begin
					if (read_pending | write_pending) begin
						state         <= HDD_ACTIVE;
						hdd_busy      <= 1'b1;
						// Read goes first when both are queued
						rd_q          <= read_pending;
						wr_q          <= ~read_pending;
						serving_write <= ~read_pending;
					end
				end
				HDD_ACTIVE: begin
					if (ack_rise) begin
						rd_q <= 1'b0;
						wr_q <= 1'b0;
					end else if (ack_fall) begin
						state    <= HDD_IDLE;
						hdd_busy <= 1'b0;
						// Only the served direction is retired
						if (serving_write)
							write_pending <= 1'b0;
						else
							read_pending <= 1'b0;
					end
				end
				default: state <= HDD_IDLE;
			endcase
		end
	end

	// Mount and write-protect state per unit
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hdd_mounted <= '0;
			hdd_protect <= '0;
		end else begin
			for (int i = 0; i < NUM_HDD; i++) begin
				if (img_mounted[i]) begin
					hdd_mounted[i] <= (img_size != '0);
					hdd_protect[i] <= img_readonly;
				end
			end
		end
	end

	// Host sees one direction at a time
	a_one_dir: assert property (@(posedge clk_sys) disable iff (reset)
		!(bus.rd && bus.wr));

	// Completion from the host releases the CPU wait on the next edge
	a_busy_release: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(bus.ack) |=> !hdd_busy);

endmodule

/* common/blk_req_if.sv */
`timescale 1ns/10ps

interface blk_req_if;
	import iigs_blk_pkg::*;

	// Block address, held stable while rd or wr is up
	blk_lba_t lba;

	// Read and write requests, one at a time
	logic rd;
	logic wr;

	// Rises to take the request, falls when the transfer is done
	logic ack;

	// Requesting side
	modport client (
		output lba,
		output rd,
		output wr,
		input  ack
	);

	// Arbiter side
	modport arbiter (
		input  lba,
		input  rd,
		input  wr,
		output ack
	);

endinterface

/* common/iigs_blk_pkg.sv */
package iigs_blk_pkg;

	// Logical block address handed to the host
	typedef logic [31:0] blk_lba_t;

	// Host image index
	// 0 and 1 are the hard-disk units, 2 and 3 the floppy drives
	typedef logic [1:0] blk_dev_t;

	// Sector number as requested by the CPU side
	typedef logic [15:0] hdd_sector_t;

	// ProDOS unit select, two units only
	typedef logic hdd_unit_t;

	// Head position of a floppy drive
	typedef logic [5:0] floppy_track_t;

	// Image size reported with a mount strobe, zero means ejected
	typedef logic [63:0] img_size_t;

	// Hard-disk units served by the sequencer
	localparam int NUM_HDD = 2;

	// Peers sharing the host port
	// Index 0 is the HDD sequencer, 1 and 2 the floppy loaders
	localparam int NUM_CLIENTS = 3;

	// Image index of the first floppy drive
	localparam int FLOPPY_DEV_BASE = 2;

endpackage
